// ==== dvi_pkg.sv ====
// shared timing, bus constants and types for the 640x480 dvi output path.
// the register table assumes a transmitter with a dual-edge 12-bit input and a pixel clock
// below 65 mhz.
package dvi_pkg;

  typedef logic [23:0] pixel_t;    // 8 bits each of red, green and blue.
  typedef logic [63:0] word_t;     // two pixels, in bits 23:0 and 55:32.
  typedef logic [11:0] half_t;
  typedef logic [11:0] coord_t;
  typedef logic [7:0]  iic_byte_t;

  // horizontal timing in pixel clocks.
  localparam int h_visible = 640;
  localparam int h_front   = 16;
  localparam int h_sync    = 96;
  localparam int h_back    = 48;
  localparam int h_total   = h_visible + h_front + h_sync + h_back;

  // vertical timing in lines.
  localparam int v_visible = 480;
  localparam int v_front   = 10;
  localparam int v_sync    = 2;
  localparam int v_back    = 33;
  localparam int v_total   = v_visible + v_front + v_sync + v_back;

  localparam int iic_quarter = 16;  // clocks per quarter of a serial bit.
  localparam logic [6:0] chip_address = 7'h76;

  // each entry is {register, value}, written in this order.
  localparam int reg_count = 4;
  localparam logic [15:0] reg_table [reg_count] = '{
    16'h49c0,  // power up the digital video path.
    16'h3308,  // pll settings for a pixel clock below 65 mhz.
    16'h3416,
    16'h3660
  };

  typedef enum logic [2:0] {
    iic_idle,
    iic_start,
    iic_send_byte,
    iic_ack,
    iic_stop,
    iic_done
  } iic_state_t;

  typedef enum logic {
    init_configure,
    init_run
  } init_state_t;

endpackage

// ==== dvi_iic_init.sv ====
// writes the register table once after reset, then holds done high.
// sda and scl are only pulled low; a pull-up outside must supply the high level.
`timescale 1ns/1ps

module dvi_iic_init (
  input  logic clock,
  input  logic reset,
  inout  wire  sda,
  inout  wire  scl,
  output logic done
);

  dvi_pkg::iic_state_t                        state;
  logic [$clog2(dvi_pkg::iic_quarter)-1:0]    div;
  logic                                       tick;
  logic [1:0]                                 phase;
  logic [$clog2(dvi_pkg::reg_count)-1:0]      entry;
  logic [1:0]                                 byte_index;
  logic [2:0]                                 bit_count;
  dvi_pkg::iic_byte_t                         cur_byte;
  logic                                       ack_ok;
  logic                                       sda_low;
  logic                                       scl_low;

  assign sda  = sda_low ? 1'b0 : 1'bz;
  assign scl  = scl_low ? 1'b0 : 1'bz;
  assign done = (state == dvi_pkg::iic_done);
  assign tick = (int'(div) == dvi_pkg::iic_quarter - 1);

  // byte 0 is the address with the write bit, then register and value.
  always_comb begin
    case (byte_index)
      2'd0:    cur_byte = {dvi_pkg::chip_address, 1'b0};
      2'd1:    cur_byte = dvi_pkg::reg_table[entry][15:8];
      default: cur_byte = dvi_pkg::reg_table[entry][7:0];
    endcase
  end

  // every bit takes four quarters, and the lines change at the end of a quarter.
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state      <= dvi_pkg::iic_idle;
      div        <= '0;
      phase      <= 2'd0;
      entry      <= '0;
      byte_index <= 2'd0;
      bit_count  <= 3'd7;
      ack_ok     <= 1'b0;
      sda_low    <= 1'b0;
      scl_low    <= 1'b0;
    end else begin
      div <= tick ? '0 : div + 1'b1;
      if (tick && state != dvi_pkg::iic_done) begin
        phase <= phase + 1'b1;
        case (state)
          dvi_pkg::iic_idle: begin
            if (phase == 2'd3) state <= dvi_pkg::iic_start;  // one bit time of free bus.
          end
          dvi_pkg::iic_start: begin
            if (phase == 2'd0) sda_low <= 1'b1;  // sda falls while scl is high.
            if (phase == 2'd2) scl_low <= 1'b1;
            if (phase == 2'd3) begin
              byte_index <= 2'd0;
              bit_count  <= 3'd7;
              state      <= dvi_pkg::iic_send_byte;
            end
          end
          dvi_pkg::iic_send_byte: begin
            if (phase == 2'd0) sda_low <= ~cur_byte[bit_count];  // msb first.
            if (phase == 2'd1) scl_low <= 1'b0;
            if (phase == 2'd3) begin
              scl_low <= 1'b1;
              if (bit_count == 3'd0) begin
                state <= dvi_pkg::iic_ack;
              end else begin
                bit_count <= bit_count - 1'b1;
              end
            end
          end
          dvi_pkg::iic_ack: begin
            if (phase == 2'd0) sda_low <= 1'b0;  // let the chip drive the ack.
            if (phase == 2'd1) scl_low <= 1'b0;
            if (phase == 2'd2) ack_ok <= ~sda;
            if (phase == 2'd3) begin
              scl_low   <= 1'b1;
              bit_count <= 3'd7;
              if (!ack_ok || byte_index == 2'd2) begin
                state <= dvi_pkg::iic_stop;
              end else begin
                byte_index <= byte_index + 1'b1;
                state      <= dvi_pkg::iic_send_byte;
              end
            end
          end
          dvi_pkg::iic_stop: begin
            if (phase == 2'd0) sda_low <= 1'b1;
            if (phase == 2'd1) scl_low <= 1'b0;
            if (phase == 2'd2) sda_low <= 1'b0;  // sda rises while scl is high.
            if (phase == 2'd3) begin
              // a refused byte sends the same entry again from the start.
              if (!ack_ok) begin
                state <= dvi_pkg::iic_start;
              end else if (int'(entry) == dvi_pkg::reg_count - 1) begin
                state <= dvi_pkg::iic_done;
              end else begin
                entry <= entry + 1'b1;
                state <= dvi_pkg::iic_start;
              end
            end
          end
          default: state <= dvi_pkg::iic_done;
        endcase
      end
    end
  end

endmodule

// ==== dvi_sync_gen.sv ====
// 640x480 timing with active-low syncs; all outputs are registered and aligned with x and y.
// out of reset the counters sit just before the horizontal sync of the last blank line.
`timescale 1ns/1ps

module dvi_sync_gen (
  input  logic            clock,
  input  logic            reset,
  output logic            hs,
  output logic            vs,
  output logic            border,
  output dvi_pkg::coord_t x,
  output dvi_pkg::coord_t y
);

  dvi_pkg::coord_t x_next;
  dvi_pkg::coord_t y_next;
  logic            h_wrap;
  logic            v_wrap;

  always_comb begin
    h_wrap = (x == dvi_pkg::coord_t'(dvi_pkg::h_total - 1));
    v_wrap = (y == dvi_pkg::coord_t'(dvi_pkg::v_total - 1));
    x_next = h_wrap ? '0 : x + 1'b1;
    y_next = y;
    if (h_wrap) begin
      y_next = v_wrap ? '0 : y + 1'b1;  // lines advance at the end of each row.
    end
  end

  // the flags are decoded from the next count so they line up with x and y.
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      x      <= dvi_pkg::coord_t'(dvi_pkg::h_visible + dvi_pkg::h_front - 1);
      y      <= dvi_pkg::coord_t'(dvi_pkg::v_total - 1);
      hs     <= 1'b1;
      vs     <= 1'b1;
      border <= 1'b1;
    end else begin
      x  <= x_next;
      y  <= y_next;
      hs <= !((x_next >= dvi_pkg::coord_t'(dvi_pkg::h_visible + dvi_pkg::h_front)) &&
              (x_next <  dvi_pkg::coord_t'(dvi_pkg::h_visible + dvi_pkg::h_front +
                                           dvi_pkg::h_sync)));
      vs <= !((y_next >= dvi_pkg::coord_t'(dvi_pkg::v_visible + dvi_pkg::v_front)) &&
              (y_next <  dvi_pkg::coord_t'(dvi_pkg::v_visible + dvi_pkg::v_front +
                                           dvi_pkg::v_sync)));
      border <= (x_next >= dvi_pkg::coord_t'(dvi_pkg::h_visible)) ||
                (y_next >= dvi_pkg::coord_t'(dvi_pkg::v_visible));
    end
  end

endmodule

// ==== dvi_pixel_unpack.sv ====
// splits each 64-bit source word into two pixels, even x from bits 23:0 and odd x from 55:32.
// the source must answer every request by the next rising edge; there is no back-pressure.
`timescale 1ns/1ps

module dvi_pixel_unpack (
  input  logic            clock,
  input  logic            reset,
  input  logic            border,
  input  dvi_pkg::coord_t x,
  input  dvi_pkg::word_t  data,
  output logic            request,
  output dvi_pkg::pixel_t pixel,
  output logic            pixel_valid
);

  dvi_pkg::word_t held;
  logic           offset;         // high while the upper pixel of held is current.
  logic           primed;
  logic           prime_request;

  // the very first word is fetched in the last cycle before the first visible line.
  // after that, the odd pixel closing each line fetches the word for the next line.
  assign prime_request = !primed && border &&
                         (x == dvi_pkg::coord_t'(dvi_pkg::h_total - 1));
  assign request       = (!border && offset) || prime_request;

  assign pixel_valid = !border;
  assign pixel       = offset ? held[55:32] : held[23:0];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      offset <= 1'b0;
      primed <= 1'b0;
    end else begin
      if (prime_request) begin
        primed <= 1'b1;
      end
      if (request) begin
        offset <= 1'b0;  // a fresh word starts at its low pixel.
      end else if (!border) begin
        offset <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (request) begin
      held <= data;  // data is valid at the edge that ends the request cycle.
    end
  end

endmodule

// ==== dvi_ddr_out.sv ====
// output stage with one cycle of latency for pixel, enable and syncs.
// dvi_d carries bits 11:0 while clock is high and bits 23:12 while it is low.
`timescale 1ns/1ps

module dvi_ddr_out (
  input  logic            clock,
  input  logic            reset,
  input  dvi_pkg::pixel_t pixel,
  input  logic            pixel_valid,
  input  logic            hs,
  input  logic            vs,
  output dvi_pkg::half_t  dvi_d,
  output logic            dvi_de,
  output logic            dvi_hs,
  output logic            dvi_vs,
  output logic            dvi_xclk_p,
  output logic            dvi_xclk_n
);

  dvi_pkg::pixel_t pixel_q;

  always_ff @(posedge clock) begin
    pixel_q <= pixel_valid ? pixel : '0;  // blank pixels go out as black.
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      dvi_de <= 1'b0;
      dvi_hs <= 1'b1;
      dvi_vs <= 1'b1;
    end else begin
      dvi_de <= pixel_valid;
      dvi_hs <= hs;
      dvi_vs <= vs;
    end
  end

  // the transmitter latches one half on each edge of its clock.
  assign dvi_d = clock ? pixel_q[11:0] : pixel_q[23:12];

  // plain logic clock pair; a real board would use a proper output register here.
  assign dvi_xclk_p = clock;
  assign dvi_xclk_n = ~clock;

endmodule

// ==== dvi_out.sv ====
// top level for a dvi transmitter at 640x480; video timing waits for chip setup to finish.
// the frame source must answer each request strobe with a word by the next rising edge.
`timescale 1ns/1ps

module dvi_out (
  input  logic            clock,
  input  logic            reset,
  input  dvi_pkg::word_t  data,
  inout  wire             sda,
  inout  wire             scl,
  output logic            request,
  output dvi_pkg::coord_t x,
  output dvi_pkg::coord_t y,
  output dvi_pkg::half_t  dvi_d,
  output logic            dvi_de,
  output logic            dvi_hs,
  output logic            dvi_vs,
  output logic            dvi_xclk_p,
  output logic            dvi_xclk_n,
  output logic            dvi_reset_b
);

  dvi_pkg::init_state_t state;
  logic                 iic_done;
  logic                 sync_reset;
  logic                 hs;
  logic                 vs;
  logic                 border;
  logic                 pixel_valid;
  dvi_pkg::pixel_t      pixel;

  // configure until the register writes are done, then run for good.
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= dvi_pkg::init_configure;
    end else if (state == dvi_pkg::init_configure && iic_done) begin
      state <= dvi_pkg::init_run;
    end
  end

  assign sync_reset  = reset || (state == dvi_pkg::init_configure);  // from a register.
  assign dvi_reset_b = ~reset;

  dvi_iic_init i_dvi_iic_init (
    .clock (clock),
    .reset (reset),
    .sda   (sda),
    .scl   (scl),
    .done  (iic_done)
  );

  dvi_sync_gen i_dvi_sync_gen (
    .clock  (clock),
    .reset  (sync_reset),
    .hs     (hs),
    .vs     (vs),
    .border (border),
    .x      (x),
    .y      (y)
  );

  dvi_pixel_unpack i_dvi_pixel_unpack (
    .clock       (clock),
    .reset       (reset),
    .border      (border),
    .x           (x),
    .data        (data),
    .request     (request),
    .pixel       (pixel),
    .pixel_valid (pixel_valid)
  );

  dvi_ddr_out i_dvi_ddr_out (
    .clock       (clock),
    .reset       (reset),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .hs          (hs),
    .vs          (vs),
    .dvi_d       (dvi_d),
    .dvi_de      (dvi_de),
    .dvi_hs      (dvi_hs),
    .dvi_vs      (dvi_vs),
    .dvi_xclk_p  (dvi_xclk_p),
    .dvi_xclk_n  (dvi_xclk_n)
  );

endmodule

// ==== dvi_out_assertions.sv ====
// request and enable rules of the pixel unpacker, bound into every dvi_pixel_unpack.
// inside a visible line a request is only legal on an odd x, ahead of the next even pixel.
`timescale 1ns/1ps

module dvi_out_assertions (
  input logic            clock,
  input logic            reset,
  input logic            border,
  input dvi_pkg::coord_t x,
  input logic            request,
  input logic            pixel_valid
);

  // the even pixel of a word is always shown from the word already held.
  a_request_at_odd_x : assert property (
    @(posedge clock) disable iff (reset) (request && pixel_valid) |-> x[0]
  ) else $error("request while an even visible pixel is shown");

  a_request_single : assert property (
    @(posedge clock) disable iff (reset) request |=> !request
  ) else $error("request lasted more than one cycle");

  a_valid_in_reset : assert property (
    @(posedge clock) reset |-> !pixel_valid
  ) else $error("pixel valid during reset");

endmodule

bind dvi_pixel_unpack dvi_out_assertions i_dvi_out_assertions (
  .clock       (clock),
  .reset       (reset),
  .border      (border),
  .x           (x),
  .request     (request),
  .pixel_valid (pixel_valid)
);

// ==== dvi_out_tb.sv ====
// directed tests for the dvi output path with a serial-bus target model and a word source.
// the target refuses the value byte of the first write once; a full run covers about two frames.
`timescale 1ns/1ps

module dvi_out_tb;

  logic               clock;
  logic               reset;
  dvi_pkg::word_t     data;
  wire                sda;
  wire                scl;
  logic               request;
  dvi_pkg::coord_t    x;
  dvi_pkg::coord_t    y;
  dvi_pkg::half_t     dvi_d;
  logic               dvi_de;
  logic               dvi_hs;
  logic               dvi_vs;
  logic               dvi_xclk_p;
  logic               dvi_xclk_n;
  logic               dvi_reset_b;
  int                 errors;
  dvi_pkg::pixel_t    expected_q[$];
  dvi_pkg::pixel_t    exp_pixel;
  dvi_pkg::iic_byte_t bytes_seen[$];
  dvi_pkg::iic_byte_t shreg;
  logic               sda_pull;
  logic               nack_next;
  logic               in_frame;
  logic               ack_phase;
  int                 bit_n;
  int                 byte_in_frame;

  localparam int config_bytes = 3 * (dvi_pkg::reg_count + 1);  // one write is sent twice.

  dvi_out i_dvi_out (
    .clock       (clock),
    .reset       (reset),
    .data        (data),
    .sda         (sda),
    .scl         (scl),
    .request     (request),
    .x           (x),
    .y           (y),
    .dvi_d       (dvi_d),
    .dvi_de      (dvi_de),
    .dvi_hs      (dvi_hs),
    .dvi_vs      (dvi_vs),
    .dvi_xclk_p  (dvi_xclk_p),
    .dvi_xclk_n  (dvi_xclk_n),
    .dvi_reset_b (dvi_reset_b)
  );

  pullup (sda);
  pullup (scl);
  assign sda = sda_pull ? 1'b0 : 1'bz;

  always #20 clock = ~clock;

  // bus target: start and stop are sda edges while scl is high.
  always @(negedge sda) begin
    if (scl === 1'b1) begin
      in_frame      = 1'b1;
      bit_n         = 0;
      byte_in_frame = 0;
    end
  end

  always @(posedge sda) begin
    if (scl === 1'b1) in_frame = 1'b0;
  end

  always @(posedge scl) begin
    if (in_frame && !ack_phase) begin
      shreg = {shreg[6:0], sda};  // msb arrives first.
      bit_n++;
    end
  end

  always @(negedge scl) begin
    if (in_frame && ack_phase) begin
      sda_pull  = 1'b0;
      ack_phase = 1'b0;
    end else if (in_frame && bit_n == 8) begin
      bytes_seen.push_back(shreg);
      byte_in_frame++;
      bit_n     = 0;
      ack_phase = 1'b1;
      if (nack_next && byte_in_frame == 3) begin
        nack_next = 1'b0;  // leave sda released, so the value byte is refused.
      end else begin
        sda_pull = 1'b1;
      end
    end
  end

  // word source: a fresh word for each request, valid before the next rising edge.
  always @(negedge clock) begin
    if (request === 1'b1) begin
      data = {$urandom, $urandom};
      expected_q.push_back(data[23:0]);
      expected_q.push_back(data[55:32]);
    end
  end

  always @(posedge clock) begin
    #1;
    if (dvi_de === 1'b1) begin
      if (expected_q.size() == 0) begin
        errors++;
        $display("expected pixel queue ran empty while de was high");
      end else begin
        exp_pixel = expected_q.pop_front();
      end
    end
    if (!reset && request === 1'b1 && bytes_seen.size() < config_bytes) begin
      errors++;
      $display("request seen before the chip configuration finished");
    end
  end

  task automatic compare_half(input string name, input dvi_pkg::half_t got,
                              input dvi_pkg::half_t exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_pixel(input string name, input dvi_pkg::pixel_t got,
                               input dvi_pkg::pixel_t exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_coord(input string name, input dvi_pkg::coord_t got,
                               input dvi_pkg::coord_t exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_byte(input string name, input dvi_pkg::iic_byte_t got,
                              input dvi_pkg::iic_byte_t exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_count(input string name, input integer got, input integer exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic step;
    @(posedge clock);
    #1;
  endtask

  task automatic wait_de(input logic level, input int limit);
    int n;
    n = 0;
    while (dvi_de !== level && n < limit) begin
      step();
      n++;
    end
    if (n == limit) begin
      errors++;
      $display("timed out waiting for dvi_de to reach %0d", level);
    end
  endtask

  task automatic wait_vs(input logic level, input int limit);
    int n;
    n = 0;
    while (dvi_vs !== level && n < limit) begin
      step();
      n++;
    end
    if (n == limit) begin
      errors++;
      $display("timed out waiting for dvi_vs to reach %0d", level);
    end
  endtask

  task automatic test_reset;
    reset = 1'b1;
    repeat (5) @(negedge clock);
    compare_bit("request", request, 1'b0);
    compare_bit("dvi_de", dvi_de, 1'b0);
    compare_bit("dvi_hs", dvi_hs, 1'b1);
    compare_bit("dvi_vs", dvi_vs, 1'b1);
    compare_bit("dvi_reset_b", dvi_reset_b, 1'b0);
    compare_bit("sda", sda, 1'b1);
    compare_bit("scl", scl, 1'b1);
    repeat (5) @(negedge clock);
    reset = 1'b0;
    step();
    compare_bit("request", request, 1'b0);
    compare_bit("dvi_de", dvi_de, 1'b0);
    compare_bit("dvi_reset_b", dvi_reset_b, 1'b1);
    compare_bit("sda", sda, 1'b1);
    compare_bit("scl", scl, 1'b1);
  endtask

  task automatic test_config;
    dvi_pkg::iic_byte_t exp[$];
    int n;
    for (int e = 0; e < dvi_pkg::reg_count; e++) begin
      for (int r = 0; r < ((e == 0) ? 2 : 1); r++) begin
        exp.push_back({dvi_pkg::chip_address, 1'b0});
        exp.push_back(dvi_pkg::reg_table[e][15:8]);
        exp.push_back(dvi_pkg::reg_table[e][7:0]);
      end
    end
    n = 0;
    while (bytes_seen.size() < exp.size() && n < 30000) begin
      step();
      n++;
    end
    if (n == 30000) begin
      errors++;
      $display("timed out waiting for the register writes");
    end
    compare_count("config byte count", bytes_seen.size(), exp.size());
    for (int i = 0; i < exp.size() && i < bytes_seen.size(); i++) begin
      compare_byte("config byte", bytes_seen[i], exp[i]);
    end
  endtask

  task automatic test_line_timing;
    int high;
    int gap;
    int low;
    for (int line = 0; line < 2; line++) begin
      wait_de(1'b0, 20000);
      wait_de(1'b1, 20000);
      high = 0;
      while (dvi_de === 1'b1 && high < 2000) begin
        high++;
        step();
      end
      compare_count("de high cycles", high, dvi_pkg::h_visible);
      gap = 0;
      while (dvi_hs !== 1'b0 && gap < 2000) begin
        gap++;
        step();
      end
      compare_count("de fall to hs cycles", gap, dvi_pkg::h_front);
      low = 0;
      while (dvi_hs === 1'b0 && low < 2000) begin
        low++;
        step();
      end
      compare_count("hs low cycles", low, dvi_pkg::h_sync);
    end
    wait_vs(1'b1, 10000);
    wait_vs(1'b0, 500000);
    low = 0;
    while (dvi_vs === 1'b0 && low < 5000) begin
      low++;
      step();
    end
    compare_count("vs low cycles", low, dvi_pkg::v_sync * dvi_pkg::h_total);
  endtask

  task automatic test_pixel_data;
    dvi_pkg::half_t hi;
    dvi_pkg::half_t lo;
    int lines;
    int n;
    wait_de(1'b0, 2000);
    wait_de(1'b1, 60000);
    lines = 0;
    n = 0;
    while (lines < 3 && n < 5000) begin
      #9 hi = dvi_d;   // middle of the high clock level.
      compare_bit("dvi_xclk_p", dvi_xclk_p, 1'b1);
      compare_bit("dvi_xclk_n", dvi_xclk_n, 1'b0);
      #20 lo = dvi_d;  // middle of the low clock level.
      compare_bit("dvi_xclk_p", dvi_xclk_p, 1'b0);
      compare_bit("dvi_xclk_n", dvi_xclk_n, 1'b1);
      if (dvi_de === 1'b1) begin
        compare_half("dvi_d high level", hi, exp_pixel[11:0]);
        compare_half("dvi_d low level", lo, exp_pixel[23:12]);
        step();
        if (dvi_de !== 1'b1) lines++;
      end else begin
        compare_pixel("dvi_d while blank", {lo, hi}, '0);  // blanking goes out as black.
        step();
      end
      n++;
    end
    if (n == 5000) begin
      errors++;
      $display("timed out checking pixel data over three lines");
    end
  endtask

  task automatic test_requests;
    int n;
    int reqs;
    n = 0;
    while (!(x == '0 && y < dvi_pkg::coord_t'(dvi_pkg::v_visible - 2)) && n < 500000) begin
      step();
      n++;
    end
    if (n == 500000) begin
      errors++;
      $display("timed out waiting for the start of a visible line");
    end
    for (int line = 0; line < 2; line++) begin
      reqs = 0;
      for (int i = 0; i < dvi_pkg::h_total; i++) begin
        if (i < dvi_pkg::h_visible) compare_coord("x", x, dvi_pkg::coord_t'(i));
        if (request === 1'b1) reqs++;
        step();
      end
      compare_count("requests per visible line", reqs, dvi_pkg::h_visible / 2);
    end
    n = 0;
    while (!(x == '0 && y == dvi_pkg::coord_t'(dvi_pkg::v_visible)) && n < 500000) begin
      step();
      n++;
    end
    if (n == 500000) begin
      errors++;
      $display("timed out waiting for the vertical border");
    end
    reqs = 0;
    for (int i = 0; i < dvi_pkg::h_total * (dvi_pkg::v_total - dvi_pkg::v_visible); i++) begin
      compare_coord("y", y, dvi_pkg::coord_t'(dvi_pkg::v_visible + i / dvi_pkg::h_total));
      if (request === 1'b1) reqs++;
      step();
    end
    compare_count("requests in vertical border", reqs, 0);
    compare_coord("x after the frame", x, '0);  // both counters wrap together.
    compare_coord("y after the frame", y, '0);
  endtask

  initial begin
    void'($urandom(32'h772d));
    clock         = 1'b0;
    reset         = 1'b1;
    data          = '0;
    errors        = 0;
    exp_pixel     = '0;
    shreg         = '0;
    sda_pull      = 1'b0;
    nack_next     = 1'b1;  // the first write is refused once.
    in_frame      = 1'b0;
    ack_phase     = 1'b0;
    bit_n         = 0;
    byte_in_frame = 0;
    test_reset();
    test_config();
    test_line_timing();
    test_pixel_data();
    test_requests();
    $display("checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== dvi_out.f ====
dvi_pkg.sv
dvi_iic_init.sv
dvi_sync_gen.sv
dvi_pixel_unpack.sv
dvi_ddr_out.sv
dvi_out.sv
dvi_out_assertions.sv
dvi_out_tb.sv

// ==== Bender.yml ====
package:
  name: dvi_out

sources:
  - dvi_pkg.sv
  - dvi_iic_init.sv
  - dvi_sync_gen.sv
  - dvi_pixel_unpack.sv
  - dvi_ddr_out.sv
  - dvi_out.sv
  - target: test
    files:
      - dvi_out_assertions.sv
      - dvi_out_tb.sv
